//--- files.f
+incdir+hdl
hdl/sram_port_pkg.sv
hdl/sync_fifo.sv
hdl/request_ingress.sv
hdl/command_issue.sv
hdl/response_egress.sv
hdl/sram_port_top.sv
tb/sram_port_chk.sv
tb/sram_port_tb.sv

//--- Bender.yml
package:
  name: sram_port

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/sram_port_pkg.sv
      - hdl/sync_fifo.sv
      - hdl/request_ingress.sv
      - hdl/command_issue.sv
      - hdl/response_egress.sv
      - hdl/sram_port_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tb/sram_port_chk.sv
      - tb/sram_port_tb.sv

//--- tb/sram_port_tb.sv
// SRAM port testbench

`include "sram_port_defs.svh"

module sram_port_tb;

  localparam int MAX_OUTSTANDING = 12;   // Request FIFO never fills
  localparam int WAIT_LIMIT      = 2000; // Cycles per wait loop
  localparam logic [`SP_ADDR_W-1:0] BASE = 32'h0000_1000;

  logic                  ap_clk;
  logic                  areset_control;
  logic                  desc_valid_i;
  logic [`SP_ADDR_W-1:0] desc_base_i;
  logic                  req_valid_i;
  logic [`SP_ID_W-1:0]   req_id_i;
  sram_port_pkg::cmd_e   req_cmd_i;
  logic [`SP_ADDR_W-1:0] req_offset_i;
  logic [`SP_DATA_W-1:0] req_wdata_i;
  logic [`SP_STRB_W-1:0] req_strb_i;
  logic                  resp_ready_i;
  logic                  mem_gnt_i;
  logic                  mem_rsp_valid_i;
  logic [`SP_DATA_W-1:0] mem_rsp_rdata_i;
  logic                  mem_req_o;
  logic [`SP_ADDR_W-1:0] mem_addr_o;
  logic                  mem_we_o;
  logic [`SP_DATA_W-1:0] mem_wdata_o;
  logic [`SP_STRB_W-1:0] mem_be_o;
  logic                  resp_valid_o;
  logic [`SP_ID_W-1:0]   resp_id_o;
  sram_port_pkg::cmd_e   resp_cmd_o;
  logic [`SP_ADDR_W-1:0] resp_addr_o;
  logic [`SP_DATA_W-1:0] resp_rdata_o;
  logic                  done_o;

  int                    sent_cnt;
  int                    resp_cnt;
  int                    err_cnt;
  logic                  ready_toggle;   // Phase 3 flickers readiness
  logic [`SP_DATA_W-1:0] mem_words [16]; // Memory model storage
  logic [`SP_DATA_W-1:0] rsp_data_q [$]; // Answers owed, in grant order

  sram_port_top dut_i (
    .ap_clk          (ap_clk         ),
    .areset_control  (areset_control ),
    .desc_valid_i    (desc_valid_i   ),
    .desc_base_i     (desc_base_i    ),
    .req_valid_i     (req_valid_i    ),
    .req_id_i        (req_id_i       ),
    .req_cmd_i       (req_cmd_i      ),
    .req_offset_i    (req_offset_i   ),
    .req_wdata_i     (req_wdata_i    ),
    .req_strb_i      (req_strb_i     ),
    .resp_ready_i    (resp_ready_i   ),
    .mem_gnt_i       (mem_gnt_i      ),
    .mem_rsp_valid_i (mem_rsp_valid_i),
    .mem_rsp_rdata_i (mem_rsp_rdata_i),
    .mem_req_o       (mem_req_o      ),
    .mem_addr_o      (mem_addr_o     ),
    .mem_we_o        (mem_we_o       ),
    .mem_wdata_o     (mem_wdata_o    ),
    .mem_be_o        (mem_be_o       ),
    .resp_valid_o    (resp_valid_o   ),
    .resp_id_o       (resp_id_o      ),
    .resp_cmd_o      (resp_cmd_o     ),
    .resp_addr_o     (resp_addr_o    ),
    .resp_rdata_o    (resp_rdata_o   ),
    .done_o          (done_o         )
  );

  bind sram_port_top sram_port_chk u_chk (.*);

  always #5 ap_clk = ~ap_clk;

  // ------------------------------------------------------------------
  // Memory model, grant side and response count
  // ------------------------------------------------------------------
  always @(posedge ap_clk) begin : mem_accept
    int idx;
    if (areset_control) begin
      rsp_data_q.delete();
    end else if (mem_req_o && mem_gnt_i) begin
      idx = int'(mem_addr_o[5:2]); // Word index wraps over 16 words
      for (int b = 0; b < `SP_STRB_W; b++) begin
        if (mem_we_o && mem_be_o[b]) begin
          mem_words[idx][8*b +: 8] = mem_wdata_o[8*b +: 8];
        end
      end
      rsp_data_q.push_back(mem_words[idx]); // Stored word for every command
    end
    if (resp_valid_o) begin
      resp_cnt++;
    end
  end

  // Random grants, delayed in-order answers, flickering readiness
  task automatic drive_memory();
    forever begin
      @(negedge ap_clk);
      mem_gnt_i    = ($urandom_range(0, 3) != 0);
      resp_ready_i = ready_toggle ? ($urandom_range(0, 2) != 0) : 1'b1;
      if (rsp_data_q.size() != 0 && $urandom_range(0, 1) == 1) begin
        mem_rsp_valid_i = 1'b1;
        mem_rsp_rdata_i = rsp_data_q.pop_front();
      end else begin
        mem_rsp_valid_i = 1'b0;
      end
    end
  endtask

  // ------------------------------------------------------------------
  // Stimulus tasks
  // ------------------------------------------------------------------
  task automatic apply_reset();
    @(negedge ap_clk);
    areset_control = 1'b1;
    repeat (5) @(negedge ap_clk);
    areset_control = 1'b0;
  endtask

  task automatic load_descriptor(input logic [`SP_ADDR_W-1:0] base);
    @(negedge ap_clk);
    desc_valid_i = 1'b1;
    desc_base_i  = base;
    @(negedge ap_clk);
    desc_valid_i = 1'b0;
  endtask

  // One-cycle request strobe
  task automatic send_request(input logic [`SP_ID_W-1:0] id,
                              input sram_port_pkg::cmd_e cmd,
                              input logic [`SP_ADDR_W-1:0] offset);
    @(negedge ap_clk);
    req_valid_i  = 1'b1;
    req_id_i     = id;
    req_cmd_i    = cmd;
    req_offset_i = offset;
    req_wdata_i  = $urandom();
    req_strb_i   = 4'($urandom_range(0, 15));
    @(negedge ap_clk);
    req_valid_i  = 1'b0;
  endtask

  // Random command, throttled by outstanding count
  task automatic send_random();
    sram_port_pkg::cmd_e cmd;
    int                  waited;
    cmd    = sram_port_pkg::cmd_e'($urandom_range(0, 4));
    waited = 0;
    while ((sent_cnt - resp_cnt >= MAX_OUTSTANDING) && (waited < WAIT_LIMIT)) begin
      @(negedge ap_clk);
      waited++;
    end
    if (waited >= WAIT_LIMIT) begin
      $display("Timeout at %0t: responses stopped coming back", $time);
      err_cnt++;
    end
    send_request(8'(sent_cnt), cmd, 32'($urandom_range(0, 15)) << 2);
    sent_cnt++;
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while (!(done_o && resp_cnt == sent_cnt) && (waited < WAIT_LIMIT)) begin
      @(negedge ap_clk);
      waited++;
    end
    if (waited >= WAIT_LIMIT) begin
      $display("Timeout at %0t: port never drained, %0d of %0d responses", $time,
               resp_cnt, sent_cnt);
      err_cnt++;
    end
  endtask

  // ------------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------------
  initial begin : main
    void'($urandom(32'hbeb6_0bf2));
    ap_clk          = 1'b0;
    areset_control  = 1'b1;
    desc_valid_i    = 1'b0;
    desc_base_i     = '0;
    req_valid_i     = 1'b0;
    req_id_i        = '0;
    req_cmd_i       = sram_port_pkg::mem_read;
    req_offset_i    = '0;
    req_wdata_i     = '0;
    req_strb_i      = '0;
    resp_ready_i    = 1'b1;
    mem_gnt_i       = 1'b0;
    mem_rsp_valid_i = 1'b0;
    mem_rsp_rdata_i = '0;
    ready_toggle    = 1'b0;
    sent_cnt        = 0;
    resp_cnt        = 0;
    err_cnt         = 0;
    for (int i = 0; i < 16; i++) begin
      mem_words[i] = 32'ha5c3_0000 ^ (i * 32'h0101_1111); // Distinct per word
    end
    fork
      drive_memory();
    join_none
    apply_reset();

    // Phase 1, no descriptor yet so nothing may issue
    for (int i = 0; i < 4; i++) begin
      send_request(8'(i), sram_port_pkg::mem_read, 32'(i) << 2);
    end
    repeat (20) @(negedge ap_clk);
    apply_reset(); // Drops the parked requests

    // Phase 2, random mix
    load_descriptor(BASE);
    for (int i = 0; i < 40; i++) begin
      send_random();
    end

    // Phase 3, consumer back-pressure
    ready_toggle = 1'b1;
    for (int i = 0; i < 40; i++) begin
      send_random();
    end
    ready_toggle = 1'b0;
    wait_drained();

    if (resp_cnt != sent_cnt) begin
      $display("Error at %0t: %0d responses for %0d requests", $time, resp_cnt, sent_cnt);
      err_cnt++;
    end
    $display("Requests %0d, responses %0d, testbench errors %0d, assertion failures %0d",
             sent_cnt, resp_cnt, err_cnt, dut_i.u_chk.fail_cnt);
    if (err_cnt == 0 && dut_i.u_chk.fail_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule : sram_port_tb

//--- tb/sram_port_chk.sv
// SRAM port assertion checker

`include "sram_port_defs.svh"

module sram_port_chk (
  input logic                  ap_clk,
  input logic                  areset_control,
  input logic                  desc_valid_i,
  input logic [`SP_ADDR_W-1:0] desc_base_i,
  input logic                  req_valid_i,
  input logic [`SP_ID_W-1:0]   req_id_i,
  input sram_port_pkg::cmd_e   req_cmd_i,
  input logic [`SP_ADDR_W-1:0] req_offset_i,
  input logic [`SP_DATA_W-1:0] req_wdata_i,
  input logic [`SP_STRB_W-1:0] req_strb_i,
  input logic                  resp_ready_i,
  input logic                  mem_gnt_i,
  input logic                  mem_rsp_valid_i,
  input logic [`SP_DATA_W-1:0] mem_rsp_rdata_i,
  input logic                  mem_req_o,
  input logic [`SP_ADDR_W-1:0] mem_addr_o,
  input logic                  mem_we_o,
  input logic [`SP_DATA_W-1:0] mem_wdata_o,
  input logic [`SP_STRB_W-1:0] mem_be_o,
  input logic                  resp_valid_o,
  input logic [`SP_ID_W-1:0]   resp_id_o,
  input sram_port_pkg::cmd_e   resp_cmd_o,
  input logic [`SP_ADDR_W-1:0] resp_addr_o,
  input logic [`SP_DATA_W-1:0] resp_rdata_o,
  input logic                  done_o
);

  sram_port_pkg::cache_request_t req_q [$];   // Accepted, not yet granted
  sram_port_pkg::resp_tag_t      gnt_q [$];   // Granted, not yet answered
  logic [`SP_DATA_W-1:0]         rdata_q [$]; // Memory data, not yet consumed

  logic [`SP_ADDR_W-1:0]         base_q;
  logic                          loaded_q;
  logic [2:0]                    req_hist_q;  // Requests of the last three edges
  int                            inflight_q;
  sram_port_pkg::cache_request_t exp_req;     // Head copies, one edge behind
  logic                          req_pend;
  sram_port_pkg::resp_tag_t      exp_tag;
  logic                          tag_pend;
  logic [`SP_DATA_W-1:0]         exp_rdata;
  logic                          rdata_pend;
  logic                          grant;
  logic                          exp_write;
  int                            fail_cnt = 0;

  assign grant     = mem_req_o && mem_gnt_i;
  assign exp_write = (exp_req.cmd == sram_port_pkg::mem_write) ||
                     (exp_req.cmd == sram_port_pkg::stream_write);

  // ------------------------------------------------------------------
  // Scoreboard
  // ------------------------------------------------------------------
  always @(posedge ap_clk) begin : scoreboard
    sram_port_pkg::cache_request_t entry;
    sram_port_pkg::resp_tag_t      tag;
    logic [`SP_ADDR_W-1:0]         base;
    if (areset_control) begin
      req_q.delete();
      gnt_q.delete();
      rdata_q.delete();
      loaded_q   <= 1'b0;
      req_hist_q <= '0;
    end else begin
      base = desc_valid_i ? desc_base_i : base_q; // Same-edge descriptor counts
      if (desc_valid_i) begin
        base_q   <= desc_base_i;
        loaded_q <= 1'b1;
      end
      if (resp_valid_o && gnt_q.size() != 0) begin
        void'(gnt_q.pop_front());
      end
      if (resp_valid_o && rdata_q.size() != 0) begin
        void'(rdata_q.pop_front());
      end
      if (grant && req_q.size() != 0) begin
        entry    = req_q.pop_front();
        tag.id   = entry.id;
        tag.cmd  = entry.cmd;
        tag.addr = entry.addr;
        gnt_q.push_back(tag);
      end
      if (mem_rsp_valid_i) begin
        rdata_q.push_back(mem_rsp_rdata_i);
      end
      if (req_valid_i) begin
        entry.id    = req_id_i;
        entry.cmd   = req_cmd_i;
        entry.addr  = base + req_offset_i; // Absolute address rule
        entry.wdata = req_wdata_i;
        entry.strb  = req_strb_i;
        req_q.push_back(entry);
      end
      req_hist_q <= {req_hist_q[1:0], req_valid_i};
    end
    // Heads as seen at the next edge
    req_pend   <= (req_q.size() != 0);
    tag_pend   <= (gnt_q.size() != 0);
    rdata_pend <= (rdata_q.size() != 0);
    inflight_q <= req_q.size() + gnt_q.size();
    if (req_q.size() != 0) begin
      exp_req <= req_q[0];
    end
    if (gnt_q.size() != 0) begin
      exp_tag <= gnt_q[0];
    end
    if (rdata_q.size() != 0) begin
      exp_rdata <= rdata_q[0];
    end
  end

  // ------------------------------------------------------------------
  // Assertions
  // ------------------------------------------------------------------
  a_reset_quiet : assert property (@(posedge ap_clk)
    $fell(areset_control) |-> !mem_req_o && !resp_valid_o && !done_o)
    else begin
      $error("Error at %0t: outputs active in first cycle after reset", $time);
      fail_cnt++;
    end

  a_issue_gate : assert property (@(posedge ap_clk) disable iff (areset_control)
    mem_req_o |-> loaded_q && ($past(resp_ready_i, 1) || $past(resp_ready_i, 2)))
    else begin
      $error("Error at %0t: mem_req_o without descriptor or readiness", $time);
      fail_cnt++;
    end

  a_grant_addr : assert property (@(posedge ap_clk) disable iff (areset_control)
    grant |-> req_pend && (mem_addr_o == exp_req.addr))
    else begin
      $error("Error at %0t: granted address %h, expected %h", $time, mem_addr_o,
             exp_req.addr);
      fail_cnt++;
    end

  // Only writes may carry byte enables
  a_grant_strb : assert property (@(posedge ap_clk) disable iff (areset_control)
    grant |-> (exp_write ? (mem_we_o && mem_be_o == exp_req.strb)
                         : (!mem_we_o && mem_be_o == '0)))
    else begin
      $error("Error at %0t: we %b be %h for command %s", $time, mem_we_o, mem_be_o,
             exp_req.cmd.name());
      fail_cnt++;
    end

  // Write data reaches the port unchanged
  a_grant_wdata : assert property (@(posedge ap_clk) disable iff (areset_control)
    grant && exp_write |-> mem_wdata_o == exp_req.wdata)
    else begin
      $error("Error at %0t: write data %h, expected %h", $time, mem_wdata_o,
             exp_req.wdata);
      fail_cnt++;
    end

  a_resp_merge : assert property (@(posedge ap_clk) disable iff (areset_control)
    resp_valid_o |-> tag_pend && rdata_pend && (resp_id_o == exp_tag.id) &&
                     (resp_cmd_o == exp_tag.cmd) && (resp_addr_o == exp_tag.addr) &&
                     (resp_rdata_o == exp_rdata))
    else begin
      $error("Error at %0t: response id %h addr %h data %h mismatch", $time, resp_id_o,
             resp_addr_o, resp_rdata_o);
      fail_cnt++;
    end

  // Fresh requests still sit in ingress, out of sight of done
  a_done_drain : assert property (@(posedge ap_clk) disable iff (areset_control)
    done_o |-> inflight_q <= $countones(req_hist_q))
    else begin
      $error("Error at %0t: done_o with %0d commands in flight", $time, inflight_q);
      fail_cnt++;
    end

endmodule : sram_port_chk

//--- hdl/sram_port_top.sv
// SRAM memory command port top level

`include "sram_port_defs.svh"

module sram_port_top (
  input  logic                  ap_clk,
  input  logic                  areset_control,
  // Kernel descriptor
  input  logic                  desc_valid_i,
  input  logic [`SP_ADDR_W-1:0] desc_base_i,
  // Memory packet request
  input  logic                  req_valid_i,
  input  logic [`SP_ID_W-1:0]   req_id_i,
  input  sram_port_pkg::cmd_e   req_cmd_i,
  input  logic [`SP_ADDR_W-1:0] req_offset_i,
  input  logic [`SP_DATA_W-1:0] req_wdata_i,
  input  logic [`SP_STRB_W-1:0] req_strb_i,
  input  logic                  resp_ready_i,
  // Memory port
  input  logic                  mem_gnt_i,
  input  logic                  mem_rsp_valid_i,
  input  logic [`SP_DATA_W-1:0] mem_rsp_rdata_i,
  output logic                  mem_req_o,
  output logic [`SP_ADDR_W-1:0] mem_addr_o,
  output logic                  mem_we_o,
  output logic [`SP_DATA_W-1:0] mem_wdata_o,
  output logic [`SP_STRB_W-1:0] mem_be_o,
  // Memory packet response
  output logic                  resp_valid_o,
  output logic [`SP_ID_W-1:0]   resp_id_o,
  output sram_port_pkg::cmd_e   resp_cmd_o,
  output logic [`SP_ADDR_W-1:0] resp_addr_o,
  output logic [`SP_DATA_W-1:0] resp_rdata_o,
  output logic                  done_o
);

  // ------------------------------------------------------------------
  // Stage interconnect
  // ------------------------------------------------------------------
  logic                          desc_loaded;
  logic                          cmd_valid;
  sram_port_pkg::cache_request_t cmd;
  logic                          tag_prog_full; // Back-pressure from egress
  logic                          tag_push;
  sram_port_pkg::resp_tag_t      tag;
  logic                          req_empty;     // Feeds done

  request_ingress u_ingress (
    .ap_clk         (ap_clk        ),
    .areset_control (areset_control),
    .desc_valid_i   (desc_valid_i  ),
    .desc_base_i    (desc_base_i   ),
    .req_valid_i    (req_valid_i   ),
    .req_id_i       (req_id_i      ),
    .req_cmd_i      (req_cmd_i     ),
    .req_offset_i   (req_offset_i  ),
    .req_wdata_i    (req_wdata_i   ),
    .req_strb_i     (req_strb_i    ),
    .desc_loaded_o  (desc_loaded   ),
    .cmd_valid_o    (cmd_valid     ),
    .cmd_o          (cmd           )
  );

  command_issue u_issue (
    .ap_clk          (ap_clk        ),
    .areset_control  (areset_control),
    .desc_loaded_i   (desc_loaded   ),
    .cmd_valid_i     (cmd_valid     ),
    .cmd_i           (cmd           ),
    .resp_ready_i    (resp_ready_i  ),
    .tag_prog_full_i (tag_prog_full ),
    .mem_gnt_i       (mem_gnt_i     ),
    .mem_req_o       (mem_req_o     ),
    .mem_addr_o      (mem_addr_o    ),
    .mem_we_o        (mem_we_o      ),
    .mem_wdata_o     (mem_wdata_o   ),
    .mem_be_o        (mem_be_o      ),
    .tag_push_o      (tag_push      ),
    .tag_o           (tag           ),
    .req_empty_o     (req_empty     )
  );

  response_egress u_egress (
    .ap_clk          (ap_clk         ),
    .areset_control  (areset_control ),
    .tag_push_i      (tag_push       ),
    .tag_i           (tag            ),
    .req_empty_i     (req_empty      ),
    .mem_rsp_valid_i (mem_rsp_valid_i),
    .mem_rsp_rdata_i (mem_rsp_rdata_i),
    .tag_prog_full_o (tag_prog_full  ),
    .resp_valid_o    (resp_valid_o   ),
    .resp_id_o       (resp_id_o      ),
    .resp_cmd_o      (resp_cmd_o     ),
    .resp_addr_o     (resp_addr_o    ),
    .resp_rdata_o    (resp_rdata_o   ),
    .done_o          (done_o         )
  );

endmodule : sram_port_top

//--- hdl/response_egress.sv
// Response tag queue and response merge

`include "sram_port_defs.svh"

module response_egress (
  input  logic                     ap_clk,
  input  logic                     areset_control,
  input  logic                     tag_push_i,
  input  sram_port_pkg::resp_tag_t tag_i,
  input  logic                     req_empty_i,
  input  logic                     mem_rsp_valid_i,
  input  logic [`SP_DATA_W-1:0]    mem_rsp_rdata_i,
  output logic                     tag_prog_full_o,
  output logic                     resp_valid_o,
  output logic [`SP_ID_W-1:0]      resp_id_o,
  output sram_port_pkg::cmd_e      resp_cmd_o,
  output logic [`SP_ADDR_W-1:0]    resp_addr_o,
  output logic [`SP_DATA_W-1:0]    resp_rdata_o,
  output logic                     done_o
);

  sram_port_pkg::resp_tag_t tag_head;
  logic                     tag_valid;  // Popped tag on dout
  logic                     tag_empty;
  logic                     rsp_valid_q;
  logic [`SP_DATA_W-1:0]    rdata_q1;
  logic [`SP_DATA_W-1:0]    rdata_q2;   // Lines up with tag_head
  logic                     empty_q;    // Both FIFOs empty at last edge

  // ------------------------------------------------------------------
  // Tag FIFO, standard read
  // ------------------------------------------------------------------
  sync_fifo #(
    .payload_t   (sram_port_pkg::resp_tag_t),
    .DEPTH       (`SP_FIFO_DEPTH           ),
    .PROG_THRESH (`SP_PROG_THRESH          ),
    .FWFT        (1'b0                     )
  ) u_tag_fifo (
    .ap_clk         (ap_clk         ),
    .areset_control (areset_control ),
    .wr_en_i        (tag_push_i     ),
    .din_i          (tag_i          ),
    .rd_en_i        (rsp_valid_q    ), // Pop one cycle after the memory answers
    .dout_o         (tag_head       ),
    .empty_o        (tag_empty      ),
    .full_o         (               ),
    .prog_full_o    (tag_prog_full_o),
    .valid_o        (tag_valid      )
  );

  // Memory data delay line
  always_ff @(posedge ap_clk) begin
    rdata_q1 <= mem_rsp_rdata_i;
    rdata_q2 <= rdata_q1;
  end

  // ------------------------------------------------------------------
  // Control registers
  // ------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      rsp_valid_q  <= 1'b0;
      resp_valid_o <= 1'b0;
      empty_q      <= 1'b0;
      done_o       <= 1'b0;
    end else begin
      rsp_valid_q  <= mem_rsp_valid_i;
      resp_valid_o <= tag_valid;
      empty_q      <= req_empty_i & tag_empty;
      done_o       <= empty_q & req_empty_i & tag_empty; // Empty over two edges
    end
  end

  // Merged response payload
  always_ff @(posedge ap_clk) begin
    if (tag_valid) begin
      resp_id_o    <= tag_head.id;
      resp_cmd_o   <= tag_head.cmd;
      resp_addr_o  <= tag_head.addr;
      resp_rdata_o <= rdata_q2;
    end
  end

endmodule : response_egress

//--- hdl/command_issue.sv
// Request queue and memory command issue

`include "sram_port_defs.svh"

module command_issue (
  input  logic                          ap_clk,
  input  logic                          areset_control,
  input  logic                          desc_loaded_i,
  input  logic                          cmd_valid_i,
  input  sram_port_pkg::cache_request_t cmd_i,
  input  logic                          resp_ready_i,
  input  logic                          tag_prog_full_i,
  input  logic                          mem_gnt_i,
  output logic                          mem_req_o,
  output logic [`SP_ADDR_W-1:0]         mem_addr_o,
  output logic                          mem_we_o,
  output logic [`SP_DATA_W-1:0]         mem_wdata_o,
  output logic [`SP_STRB_W-1:0]         mem_be_o,
  output logic                          tag_push_o,
  output sram_port_pkg::resp_tag_t      tag_o,
  output logic                          req_empty_o
);

  sram_port_pkg::cache_request_t head;       // FWFT head of request FIFO
  logic                          head_valid;
  logic                          ready_q;    // Consumer ready, one cycle late
  logic                          is_write;
  logic                          grant;

  // ------------------------------------------------------------------
  // Request FIFO, first word fall through
  // ------------------------------------------------------------------
  sync_fifo #(
    .payload_t   (sram_port_pkg::cache_request_t),
    .DEPTH       (`SP_FIFO_DEPTH                ),
    .PROG_THRESH (`SP_PROG_THRESH               ),
    .FWFT        (1'b1                          )
  ) u_req_fifo (
    .ap_clk         (ap_clk        ),
    .areset_control (areset_control),
    .wr_en_i        (cmd_valid_i   ),
    .din_i          (cmd_i         ),
    .rd_en_i        (grant         ), // Pop on the granting edge
    .dout_o         (head          ),
    .empty_o        (req_empty_o   ),
    .full_o         (              ),
    .prog_full_o    (              ),
    .valid_o        (head_valid    )
  );

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= resp_ready_i;
    end
  end

  // ------------------------------------------------------------------
  // Issue gating
  // ------------------------------------------------------------------
  assign mem_req_o = head_valid & desc_loaded_i & ~tag_prog_full_i & ready_q;
  assign grant     = mem_req_o & mem_gnt_i;

  assign is_write = (head.cmd == sram_port_pkg::mem_write) |
                    (head.cmd == sram_port_pkg::stream_write);

  assign mem_addr_o  = head.addr;
  assign mem_wdata_o = head.wdata;
  assign mem_we_o    = is_write;
  assign mem_be_o    = head.strb & {`SP_STRB_W{is_write}}; // No bytes for reads and flush

  // Tag follows the command into the response FIFO
  assign tag_push_o = grant;
  always_comb begin
    tag_o.id   = head.id;
    tag_o.cmd  = head.cmd;
    tag_o.addr = head.addr;
  end

endmodule : command_issue

//--- hdl/request_ingress.sv
// Descriptor and request input pipeline

`include "sram_port_defs.svh"

module request_ingress (
  input  logic                          ap_clk,
  input  logic                          areset_control,
  input  logic                          desc_valid_i,
  input  logic [`SP_ADDR_W-1:0]         desc_base_i,
  input  logic                          req_valid_i,
  input  logic [`SP_ID_W-1:0]           req_id_i,
  input  sram_port_pkg::cmd_e           req_cmd_i,
  input  logic [`SP_ADDR_W-1:0]         req_offset_i,
  input  logic [`SP_DATA_W-1:0]         req_wdata_i,
  input  logic [`SP_STRB_W-1:0]         req_strb_i,
  output logic                          desc_loaded_o,
  output logic                          cmd_valid_o,
  output sram_port_pkg::cache_request_t cmd_o
);

  logic [`SP_ADDR_W-1:0]         desc_base_q;
  logic                          s1_valid_q;
  sram_port_pkg::cache_request_t s1_req_q; // addr still holds the offset

  // ------------------------------------------------------------------
  // Descriptor register
  // ------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      desc_loaded_o <= 1'b0;
    end else if (desc_valid_i) begin
      desc_loaded_o <= 1'b1; // Sticky until reset
    end
  end

  always_ff @(posedge ap_clk) begin
    if (desc_valid_i) begin
      desc_base_q <= desc_base_i; // Any new descriptor replaces the base
    end
  end

  // ------------------------------------------------------------------
  // Two-stage request pipeline
  // ------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      s1_valid_q  <= 1'b0;
      cmd_valid_o <= 1'b0;
    end else begin
      s1_valid_q  <= req_valid_i;  // Edge N
      cmd_valid_o <= s1_valid_q;   // Edge N+1, FIFO push at N+2
    end
  end

  // Stage 1 captures the raw packet
  always_ff @(posedge ap_clk) begin
    s1_req_q.id    <= req_id_i;
    s1_req_q.cmd   <= req_cmd_i;
    s1_req_q.addr  <= req_offset_i;
    s1_req_q.wdata <= req_wdata_i;
    s1_req_q.strb  <= req_strb_i;
  end

  // Stage 2 maps offset to absolute address
  always_ff @(posedge ap_clk) begin
    cmd_o      <= s1_req_q;
    cmd_o.addr <= desc_base_q + s1_req_q.addr;
  end

endmodule : request_ingress

//--- hdl/sync_fifo.sv
// Synchronous FIFO with programmable full

module sync_fifo #(
  parameter type payload_t   = logic [31:0],
  parameter int  DEPTH       = 16,
  parameter int  PROG_THRESH = 8,
  parameter bit  FWFT        = 1'b1 // 1 head always visible, 0 registered read
) (
  input  logic     ap_clk,
  input  logic     areset_control,
  input  logic     wr_en_i,
  input  payload_t din_i,
  input  logic     rd_en_i,
  output payload_t dout_o,
  output logic     empty_o,
  output logic     full_o,
  output logic     prog_full_o,
  output logic     valid_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  payload_t         mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W:0]   count_q;  // Occupancy, one bit wider than pointers
  logic             push;
  logic             pop;

  assign push = wr_en_i & ~full_o;  // Writes into a full FIFO are dropped
  assign pop  = rd_en_i & ~empty_o;

  assign empty_o     = (count_q == '0);
  assign full_o      = (count_q == (PTR_W+1)'(DEPTH));
  assign prog_full_o = (count_q >= (PTR_W+1)'(PROG_THRESH));

  // ------------------------------------------------------------------
  // Pointers and occupancy
  // ------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH-1)) ? '0 : wr_ptr_q + 1'b1; // Wrap
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH-1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q; // Idle or push with pop
      endcase
    end
  end

  // Storage
  always_ff @(posedge ap_clk) begin
    if (push) begin
      mem_q[wr_ptr_q] <= din_i;
    end
  end

  // ------------------------------------------------------------------
  // Read side
  // ------------------------------------------------------------------
  if (FWFT) begin : g_fwft
    assign dout_o  = mem_q[rd_ptr_q]; // Head shows while not empty
    assign valid_o = ~empty_o;
  end else begin : g_std
    payload_t dout_q;
    logic     valid_q;

    always_ff @(posedge ap_clk) begin
      if (areset_control) begin
        valid_q <= 1'b0;
      end else begin
        valid_q <= pop; // One cycle after rd_en_i
      end
    end

    always_ff @(posedge ap_clk) begin
      if (pop) begin
        dout_q <= mem_q[rd_ptr_q];
      end
    end

    assign dout_o  = dout_q;
    assign valid_o = valid_q;
  end

endmodule : sync_fifo

//--- hdl/sram_port_pkg.sv
// SRAM port command and payload types

`include "sram_port_defs.svh"

package sram_port_pkg;

  // ------------------------------------------------------------------
  // Command encoding
  // ------------------------------------------------------------------
  typedef enum logic [`SP_CMD_W-1:0] {
    mem_read     = 0, // Plain word read
    mem_write    = 1, // Strobed word write
    stream_read  = 2,
    stream_write = 3, // Treated as a write on the port
    cache_flush  = 4  // Issued as a read, no bytes written
  } cmd_e;

  // ------------------------------------------------------------------
  // Issued command
  // ------------------------------------------------------------------
  // Leaves ingress with an absolute address
  // Inside ingress stage 1 the addr field still holds the offset
  typedef struct packed {
    logic [`SP_ID_W-1:0]   id;    // Packet id, returned with the response
    cmd_e                  cmd;
    logic [`SP_ADDR_W-1:0] addr;  // Base plus offset
    logic [`SP_DATA_W-1:0] wdata;
    logic [`SP_STRB_W-1:0] strb;  // Raw strobe, masked at issue
  } cache_request_t;

  // ------------------------------------------------------------------
  // Response tag
  // ------------------------------------------------------------------
  // Kept per granted command until memory answers
  // No data here, rdata joins it in egress
  typedef struct packed {
    logic [`SP_ID_W-1:0]   id;
    cmd_e                  cmd;
    logic [`SP_ADDR_W-1:0] addr;
  } resp_tag_t;

endpackage : sram_port_pkg

//--- hdl/sram_port_defs.svh
// SRAM port width and depth macros

`ifndef SRAM_PORT_DEFS_SVH
`define SRAM_PORT_DEFS_SVH

// ------------------------------------------------------------------
// Bus widths
// ------------------------------------------------------------------
`define SP_ADDR_W 32 // Byte address into memory
`define SP_DATA_W 32 // One memory word
`define SP_STRB_W 4  // One bit per data byte

// Packet fields carried alongside each command
`define SP_ID_W  8
`define SP_CMD_W 3 // Wide enough for the five commands

// ------------------------------------------------------------------
// Queue sizing
// ------------------------------------------------------------------
// Request FIFO and response tag FIFO share one depth
`define SP_FIFO_DEPTH 16

// Tag FIFO occupancy at which issue stops
// Leaves room for commands already granted
`define SP_PROG_THRESH 8

`endif // SRAM_PORT_DEFS_SVH
